// File: hw/rv_pkg.sv
package rv_pkg;

	////////////////////////////////////////////////////
	// widths and types
	////////////////////////////////////////////////////
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OPCODE_W = 7;
	localparam int ALU_OP_W = 3;

	// data, address and instruction words share one width
	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [ALU_OP_W-1:0] alu_op_t;

	////////////////////////////////////////////////////
	// major opcodes
	////////////////////////////////////////////////////
	localparam opcode_t OP_R = 7'b0110011;
	localparam opcode_t OP_IMM = 7'b0010011;
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL = 7'b1101111;

	////////////////////////////////////////////////////
	// alu operations
	////////////////////////////////////////////////////
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_SLT = 3'd5;

	// addi x0, x0, 0
	localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
	input logic clock,
	input logic reset,
	input reg_addr_t ra_a,
	input reg_addr_t ra_b,
	input reg_addr_t wa,
	input logic we,
	input word_t wd,
	output word_t rd_a,
	output word_t rd_b
);

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// same-cycle write shows through to decode
	assign rd_a = (ra_a == '0) ? '0 : (we && wa == ra_a) ? wd : regs[ra_a];
	assign rd_b = (ra_b == '0) ? '0 : (we && wa == ra_b) ? wd : regs[ra_b];

endmodule

// File: hw/decoder.sv
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
	input word_t instr,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output reg_addr_t rd,
	output word_t imm,
	output alu_op_t alu_op,
	output logic alu_src_imm,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output logic mem_to_reg,
	output logic branch,
	output logic jump
);

	localparam logic [2:0] F3_LW = 3'b010;
	localparam logic [2:0] F3_SW = 3'b010;
	localparam logic [2:0] F3_BEQ = 3'b000;

	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_b, imm_j;

	assign opcode = instr[6:0];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign funct7 = instr[31:25];

	// immediate formats
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// shared by register and immediate arithmetic
	function automatic alu_op_t arith_op(logic [2:0] f3, logic sub);
		case (f3)
			3'b000: return sub ? ALU_SUB : ALU_ADD;
			3'b010: return ALU_SLT;
			3'b100: return ALU_XOR;
			3'b110: return ALU_OR;
			3'b111: return ALU_AND;
			default: return ALU_ADD;
		endcase
	endfunction

	always_comb begin
		imm = '0;
		alu_op = ALU_ADD;
		alu_src_imm = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		mem_to_reg = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		case (opcode)
			OP_R: begin
				reg_write = 1'b1;
				alu_op = arith_op(funct3, funct7[5]);
			end
			OP_IMM: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				imm = imm_i;
				alu_op = arith_op(funct3, 1'b0);
			end
			OP_LOAD: begin
				if (funct3 == F3_LW) begin
					reg_write = 1'b1;
					mem_read = 1'b1;
					mem_to_reg = 1'b1;
					alu_src_imm = 1'b1;
					imm = imm_i;
				end
			end
			OP_STORE: begin
				if (funct3 == F3_SW) begin
					mem_write = 1'b1;
					alu_src_imm = 1'b1;
					imm = imm_s;
				end
			end
			OP_BRANCH: begin
				// compare by subtraction, zero flag decides
				if (funct3 == F3_BEQ) begin
					branch = 1'b1;
					alu_op = ALU_SUB;
					imm = imm_b;
				end
			end
			OP_JAL: begin
				jump = 1'b1;
				reg_write = 1'b1;
				imm = imm_j;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
	input word_t in_a,
	input word_t in_b,
	input alu_op_t op,
	output word_t result,
	output logic zero
);

	always_comb begin
		case (op)
			ALU_ADD: begin
				result = in_a + in_b;
			end
			ALU_SUB: begin
				result = in_a - in_b;
			end
			ALU_AND: begin
				result = in_a & in_b;
			end
			ALU_OR: begin
				result = in_a | in_b;
			end
			ALU_XOR: begin
				result = in_a ^ in_b;
			end
			ALU_SLT: begin
				// signed compare
				result = word_t'($signed(in_a) < $signed(in_b));
			end
			default: begin
				result = in_a + in_b;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
	input reg_addr_t ifid_rs1,
	input reg_addr_t ifid_rs2,
	input reg_addr_t idex_rd,
	input logic idex_mem_read,
	input logic jump,
	input logic branch_taken,
	output logic stall,
	output logic flush_ifid,
	output logic flush_idex,
	output logic flush_exmem
);

	logic load_use;

	// load in execute feeding the instruction in decode
	// jal reads no register, so it never waits
	always_comb begin
		load_use = 1'b0;
		if (idex_mem_read && idex_rd != '0 && !jump) begin
			if (idex_rd == ifid_rs1 || idex_rd == ifid_rs2) begin
				load_use = 1'b1;
			end
		end
	end

	// taken beq overrides everything younger
	assign stall = load_use && !branch_taken;

	//////////////////////////////////////////////////
	// flushes
	//////////////////////////////////////////////////

	// jal drops the one slot fetched behind it
	assign flush_ifid = branch_taken || jump;

	// load-use bubble goes in behind the load
	assign flush_idex = branch_taken || load_use;

	assign flush_exmem = branch_taken;

endmodule

// File: hw/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import rv_pkg::*; (
	input reg_addr_t idex_rs1,
	input reg_addr_t idex_rs2,
	input reg_addr_t exmem_rd,
	input reg_addr_t memwb_rd,
	input logic exmem_reg_write,
	input logic memwb_reg_write,
	input word_t idex_rd_a,
	input word_t idex_rd_b,
	input word_t exmem_result,
	input word_t wb_data,
	output word_t op_a,
	output word_t op_b
);

	// x0 is never a bypass source
	function automatic logic hit(reg_addr_t rs, reg_addr_t rd, logic we);
		return we && rd != '0 && rd == rs;
	endfunction

	// later assignment wins, so the younger producer takes priority
	always_comb begin
		op_a = idex_rd_a;
		if (hit(idex_rs1, memwb_rd, memwb_reg_write)) begin
			op_a = wb_data;
		end
		if (hit(idex_rs1, exmem_rd, exmem_reg_write)) begin
			op_a = exmem_result;
		end
	end

	always_comb begin
		op_b = idex_rd_b;
		if (hit(idex_rs2, memwb_rd, memwb_reg_write)) begin
			op_b = wb_data;
		end
		if (hit(idex_rs2, exmem_rd, exmem_reg_write)) begin
			op_b = exmem_result;
		end
	end

endmodule

// File: hw/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import rv_pkg::*; #(
	parameter word_t reset_pc = '0
) (
	input logic clock,
	input logic reset,
	output word_t pc,
	input word_t instr,
	output word_t data_addr,
	output word_t data_out,
	output logic ren,
	output logic wen,
	input word_t data_in
);

	logic stall, flush_ifid, flush_idex, flush_exmem, branch_taken;
	word_t pc_next;

	word_t ifid_instr, ifid_pc;

	reg_addr_t id_rs1, id_rs2, id_rd;
	word_t id_imm, id_rd_a, id_rd_b, jal_target;
	alu_op_t id_alu_op;
	logic id_alu_src_imm, id_mem_read, id_mem_write, id_reg_write;
	logic id_mem_to_reg, id_branch, id_jump;

	logic idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg;
	logic idex_branch, idex_jump, idex_alu_src_imm;
	word_t idex_pc, idex_imm, idex_rd_a, idex_rd_b;
	reg_addr_t idex_rs1, idex_rs2, idex_rd;
	alu_op_t idex_alu_op;

	word_t op_a, op_b, alu_a, alu_b, ex_result, branch_target;
	logic ex_zero;

	logic exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_mem_to_reg, exmem_branch;
	word_t exmem_result, exmem_store_data, exmem_target;
	reg_addr_t exmem_rd;
	logic exmem_zero;

	logic memwb_reg_write, memwb_mem_to_reg;
	word_t memwb_result, memwb_load, wb_data;
	reg_addr_t memwb_rd;

	//////////////////////////////////////////////////
	// fetch
	//////////////////////////////////////////////////

	// beq from memory stage beats jal from decode
	always_comb begin
		if (branch_taken) begin
			pc_next = exmem_target;
		end else if (stall) begin
			pc_next = pc;
		end else if (id_jump) begin
			pc_next = jal_target;
		end else begin
			pc_next = pc + word_t'(4);
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
		end else begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ifid_instr <= NOP_INSTR;
		end else if (flush_ifid) begin
			ifid_instr <= NOP_INSTR;
		end else if (!stall) begin
			ifid_instr <= instr;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			ifid_pc <= pc;
		end
	end

	//////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////
	decoder u_decoder (
		.instr(ifid_instr),
		.rs1(id_rs1),
		.rs2(id_rs2),
		.rd(id_rd),
		.imm(id_imm),
		.alu_op(id_alu_op),
		.alu_src_imm(id_alu_src_imm),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.reg_write(id_reg_write),
		.mem_to_reg(id_mem_to_reg),
		.branch(id_branch),
		.jump(id_jump)
	);

	reg_file u_reg_file (
		.clock(clock),
		.reset(reset),
		.ra_a(id_rs1),
		.ra_b(id_rs2),
		.wa(memwb_rd),
		.we(memwb_reg_write),
		.wd(wb_data),
		.rd_a(id_rd_a),
		.rd_b(id_rd_b)
	);

	hazard_unit u_hazard_unit (
		.ifid_rs1(id_rs1),
		.ifid_rs2(id_rs2),
		.idex_rd(idex_rd),
		.idex_mem_read(idex_mem_read),
		.jump(id_jump),
		.branch_taken(branch_taken),
		.stall(stall),
		.flush_ifid(flush_ifid),
		.flush_idex(flush_idex),
		.flush_exmem(flush_exmem)
	);

	assign jal_target = ifid_pc + id_imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			{idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg} <= '0;
			{idex_branch, idex_jump, idex_alu_src_imm} <= '0;
		end else if (flush_idex) begin
			{idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg} <= '0;
			{idex_branch, idex_jump, idex_alu_src_imm} <= '0;
		end else begin
			idex_reg_write <= id_reg_write;
			idex_mem_read <= id_mem_read;
			idex_mem_write <= id_mem_write;
			idex_mem_to_reg <= id_mem_to_reg;
			idex_branch <= id_branch;
			idex_jump <= id_jump;
			idex_alu_src_imm <= id_alu_src_imm;
		end
	end

	always_ff @(posedge clock) begin
		idex_pc <= ifid_pc;
		idex_imm <= id_imm;
		idex_rs1 <= id_rs1;
		idex_rs2 <= id_rs2;
		idex_rd <= id_rd;
		idex_alu_op <= id_alu_op;
		idex_rd_a <= id_rd_a;
		idex_rd_b <= id_rd_b;
	end

	//////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////
	forward_unit u_forward_unit (
		.idex_rs1(idex_rs1),
		.idex_rs2(idex_rs2),
		.exmem_rd(exmem_rd),
		.memwb_rd(memwb_rd),
		.exmem_reg_write(exmem_reg_write),
		.memwb_reg_write(memwb_reg_write),
		.idex_rd_a(idex_rd_a),
		.idex_rd_b(idex_rd_b),
		.exmem_result(exmem_result),
		.wb_data(wb_data),
		.op_a(op_a),
		.op_b(op_b)
	);

	// jal link value is pc + 4
	assign alu_a = idex_jump ? idex_pc : op_a;
	assign alu_b = idex_jump ? word_t'(4) : (idex_alu_src_imm ? idex_imm : op_b);

	alu u_alu (
		.in_a(alu_a),
		.in_b(alu_b),
		.op(idex_alu_op),
		.result(ex_result),
		.zero(ex_zero)
	);

	assign branch_target = idex_pc + idex_imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			{exmem_reg_write, exmem_mem_read, exmem_mem_write} <= '0;
			{exmem_mem_to_reg, exmem_branch} <= '0;
		end else if (flush_exmem) begin
			{exmem_reg_write, exmem_mem_read, exmem_mem_write} <= '0;
			{exmem_mem_to_reg, exmem_branch} <= '0;
		end else begin
			exmem_reg_write <= idex_reg_write;
			exmem_mem_read <= idex_mem_read;
			exmem_mem_write <= idex_mem_write;
			exmem_mem_to_reg <= idex_mem_to_reg;
			exmem_branch <= idex_branch;
		end
	end

	always_ff @(posedge clock) begin
		exmem_result <= ex_result;
		exmem_store_data <= op_b;
		exmem_target <= branch_target;
		exmem_rd <= idex_rd;
		exmem_zero <= ex_zero;
	end

	//////////////////////////////////////////////////
	// memory
	//////////////////////////////////////////////////
	assign data_addr = exmem_result;
	assign data_out = exmem_store_data;
	assign ren = exmem_mem_read;
	assign wen = exmem_mem_write;
	assign branch_taken = exmem_branch && exmem_zero;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			memwb_reg_write <= 1'b0;
			memwb_mem_to_reg <= 1'b0;
		end else begin
			memwb_reg_write <= exmem_reg_write;
			memwb_mem_to_reg <= exmem_mem_to_reg;
		end
	end

	always_ff @(posedge clock) begin
		memwb_result <= exmem_result;
		memwb_load <= data_in;
		memwb_rd <= exmem_rd;
	end

	//////////////////////////////////////////////////
	// writeback
	//////////////////////////////////////////////////
	assign wb_data = memwb_mem_to_reg ? memwb_load : memwb_result;

endmodule

// File: verification/iss_model.svh
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

////////////////////////////////////////////////////
// random source
////////////////////////////////////////////////////

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// one step per bit, newest bit lands in bit 0
function automatic word_t take_bits(int n);
	word_t v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

////////////////////////////////////////////////////
// encoders
////////////////////////////////////////////////////
function automatic word_t enc_r(logic sub, logic [2:0] f3, reg_addr_t rd,
		reg_addr_t rs1, reg_addr_t rs2);
	return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OP_R};
endfunction

function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
		reg_addr_t rd, opcode_t opc);
	return {imm, rs1, f3, rd, opc};
endfunction

// always sw
function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
endfunction

// always beq
function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs1, reg_addr_t rs2);
	return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

// sel 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 and 7 fold onto add and sub
function automatic logic [2:0] arith_f3(word_t sel);
	case (sel[2:0])
		3'd2: return 3'b111;
		3'd3: return 3'b110;
		3'd4: return 3'b100;
		3'd5: return 3'b010;
		default: return 3'b000;
	endcase
endfunction

////////////////////////////////////////////////////
// program and data
////////////////////////////////////////////////////
task automatic build_program();
	int k;
	word_t cls, sel, mem_off;
	reg_addr_t rd, rs1, rs2;
	// unused words hold addi x0 with the word index as immediate
	for (int i = 0; i < IMEM_WORDS; i++) begin
		imem[i] = enc_i(12'(i), '0, 3'b000, '0, OP_IMM);
	end
	for (int i = 0; i < N_INIT; i++) begin
		imem[i] = enc_i(12'(take_bits(12)), '0, 3'b000, reg_addr_t'(i + 1), OP_IMM);
	end
	for (int i = N_INIT; i < DUMP_START; i++) begin
		rd = reg_addr_t'(take_bits(4));
		rs1 = reg_addr_t'(take_bits(4));
		rs2 = reg_addr_t'(take_bits(4));
		cls = take_bits(4);
		sel = take_bits(3);
		k = 1 + int'(take_bits(2));
		mem_off = DATA_BASE + 4 * take_bits(6);
		// forward jumps never land past the dump
		if (i + k > DUMP_START) begin
			k = DUMP_START - i;
		end
		if (cls < 6) begin
			imem[i] = enc_r(sel == 1 || sel == 7, arith_f3(sel), rd, rs1, rs2);
		end else if (cls < 9) begin
			imem[i] = enc_i(12'(take_bits(12)), rs1, arith_f3(sel), rd, OP_IMM);
		end else if (cls < 11) begin
			imem[i] = enc_i(12'(mem_off), '0, 3'b010, rd, OP_LOAD);
		end else if (cls < 13) begin
			imem[i] = enc_s(12'(mem_off), rs2, '0);
		end else if (cls < 15) begin
			// equal operands make roughly half the branches taken
			if (sel[0]) begin
				rs2 = rs1;
			end
			imem[i] = enc_b(13'(4 * k), rs1, rs2);
		end else begin
			imem[i] = enc_j(21'(4 * k), rd);
		end
	end
	for (int r = 1; r < 32; r++) begin
		imem[DUMP_START + r - 1] = enc_s(12'(DUMP_BASE + 4 * (r - 1)), reg_addr_t'(r), '0);
	end
	// jal x0 onto itself
	imem[HALT_IDX] = enc_j('0, '0);
endtask

task automatic fill_data();
	for (int i = 0; i < DMEM_WORDS; i++) begin
		dmem[i] = take_bits(32);
		model_mem[i] = dmem[i];
	end
endtask

////////////////////////////////////////////////////
// architectural model
////////////////////////////////////////////////////
function automatic word_t model_arith(logic [2:0] f3, logic sub, word_t a, word_t b);
	case (f3)
		3'b000: return sub ? a - b : a + b;
		3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'b100: return a ^ b;
		3'b110: return a | b;
		default: return a & b;
	endcase
endfunction

task automatic run_model();
	word_t mpc, ins, a, b, addr, nxt, imm_i, imm_s, imm_b, imm_j;
	reg_addr_t rd;
	int steps;
	for (int r = 0; r < 32; r++) begin
		model_regs[r] = '0;
	end
	mpc = RESET_PC;
	steps = 0;
	while (mpc != HALT_ADDR && steps < PROG_LEN) begin
		ins = imem[mpc[9:2]];
		rd = ins[11:7];
		a = model_regs[ins[19:15]];
		b = model_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		nxt = mpc + 4;
		case (opcode_t'(ins[6:0]))
			OP_R: begin
				model_regs[rd] = model_arith(ins[14:12], ins[30], a, b);
			end
			OP_IMM: begin
				model_regs[rd] = model_arith(ins[14:12], 1'b0, a, imm_i);
			end
			OP_LOAD: begin
				addr = a + imm_i;
				model_regs[rd] = model_mem[addr[10:2]];
			end
			OP_STORE: begin
				addr = a + imm_s;
				exp_addr.push_back(addr);
				exp_data.push_back(b);
				model_mem[addr[10:2]] = b;
			end
			OP_BRANCH: begin
				if (a == b) begin
					nxt = mpc + imm_b;
				end
			end
			OP_JAL: begin
				model_regs[rd] = mpc + 4;
				nxt = mpc + imm_j;
			end
			default: begin
			end
		endcase
		model_regs[0] = '0;
		mpc = nxt;
		steps++;
	end
endtask

`endif

// File: verification/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import rv_pkg::*; ();

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 512;
	localparam int N_INIT = 8;
	localparam int DUMP_START = 208;
	localparam int HALT_IDX = 239;
	localparam int PROG_LEN = 240;
	localparam word_t HALT_ADDR = 32'(HALT_IDX * 4);
	localparam word_t DATA_BASE = 32'h0000_0400;
	localparam word_t DUMP_BASE = 32'h0000_0500;
	localparam word_t RESET_PC = 32'h0000_0000;
	localparam logic [15:0] SEED = 16'd47152;
	localparam int RESET_CYCLES = 10;
	localparam int TIMEOUT = 4 * PROG_LEN + 100;
	// memory stage trails fetch by three cycles
	localparam int DRAIN_CYCLES = 4;

	logic clock;
	logic reset;
	word_t pc, instr, data_addr, data_out, data_in;
	logic ren, wen;

	word_t imem [IMEM_WORDS];
	word_t dmem [DMEM_WORDS];
	word_t model_mem [DMEM_WORDS];
	word_t model_regs [32];
	word_t exp_addr [$];
	word_t exp_data [$];
	logic [15:0] lfsr_state;
	word_t e_addr, e_data;
	int cycles = 0;
	int checks = 0;
	int n_expected = 0;
	int err_reset = 0;
	int err_dump = 0;
	int err_mem = 0;
	int err_flow = 0;
	int err_done = 0;

	`include "iss_model.svh"

	cpu_core #(
		.reset_pc(RESET_PC)
	) DUT (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.data_addr(data_addr),
		.data_out(data_out),
		.ren(ren),
		.wen(wen),
		.data_in(data_in)
	);

	// both memories answer in the same cycle
	assign instr = imem[pc[9:2]];
	assign data_in = ren ? dmem[data_addr[10:2]] : '0;

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) begin
		if (reset) begin
			cycles++;
		end
	end

	task automatic compare(input string name, input word_t got, input word_t want,
			inout int errs);
		checks++;
		if (got !== want) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, want);
			errs++;
		end
	endtask

	task automatic check_reset_outputs();
		compare("pc", pc, RESET_PC, err_reset);
		compare("ren", word_t'(ren), '0, err_reset);
		compare("wen", word_t'(wen), '0, err_reset);
	endtask

	//////////////////////////////////////////////////
	// store monitor and data memory write
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		if (reset && wen) begin
			dmem[data_addr[10:2]] <= data_out;
			if (exp_addr.size() == 0) begin
				$display("extra store at %0t ns to address %h that the model never made",
					$time, data_addr);
				err_flow++;
			end else begin
				e_addr = exp_addr.pop_front();
				e_data = exp_data.pop_front();
				// dump area holds the final register values
				if (e_addr >= DUMP_BASE) begin
					compare("data_addr", data_addr, e_addr, err_dump);
					compare("data_out", data_out, e_data, err_dump);
				end else begin
					compare("data_addr", data_addr, e_addr, err_mem);
					compare("data_out", data_out, e_data, err_mem);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		reset = 1'b0;
		lfsr_state = SEED;
		build_program();
		fill_data();
		run_model();
		n_expected = exp_addr.size();

		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_reset_outputs();
		end
		reset = 1'b1;
		#1;
		check_reset_outputs();
		$display("test reset: %0d errors", err_reset);

		while (!(pc == HALT_ADDR && exp_addr.size() == 0) && cycles < TIMEOUT) begin
			@(negedge clock);
		end
		if (cycles >= TIMEOUT) begin
			if (pc != HALT_ADDR) begin
				$display("timeout after %0d cycles: pc never reached the halt address %h",
					cycles, HALT_ADDR);
			end else begin
				$display("timeout after %0d cycles: halted with stores still pending", cycles);
			end
			err_done++;
		end else begin
			repeat (DRAIN_CYCLES) @(negedge clock);
		end
		if (exp_addr.size() != 0) begin
			$display("%0d of %0d expected stores never appeared", exp_addr.size(), n_expected);
			err_flow++;
		end

		$display("test arithmetic and forwarding (register dump): %0d errors", err_dump);
		$display("test memory stores in program order: %0d errors", err_mem);
		$display("test control flow (extra or missing stores): %0d errors", err_flow);
		$display("test completion: %0d errors after %0d cycles", err_done, cycles);
		$display("summary: %0d checks, %0d stores expected, %0d errors", checks, n_expected,
			err_reset + err_dump + err_mem + err_flow + err_done);
		if (err_reset + err_dump + err_mem + err_flow + err_done == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+verification
hw/rv_pkg.sv
hw/reg_file.sv
hw/decoder.sv
hw/alu.sv
hw/hazard_unit.sv
hw/forward_unit.sv
hw/cpu_core.sv
verification/tb_cpu.sv
